// File: Makefile
# Verilator flow for the tune player

VERILATOR ?= verilator
TOP       ?= music_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --timing --assert --timescale 1ns/1ps

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim.f
source/music_pkg.sv
source/score_rom.sv
source/ms_tick.sv
source/note_sequencer.sv
source/tone_generator.sv
source/seg_display.sv
source/music_top.sv
verification/music_tb.sv

// File: source/ms_tick.sv
module ms_tick import music_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic [TPM_W-1:0] ticks_per_milli,
  output logic             ms_strobe
);

  logic [TPM_W-1:0] tick_cnt;
  logic             wrap;

  assign wrap = (tick_cnt == ticks_per_milli - TPM_W'(1));

  always_ff @(posedge clk) begin
    if (rst) begin
      tick_cnt  <= '0;
      ms_strobe <= 1'b0;
    end else begin
      ms_strobe <= wrap;  // one clock per wrap
      if (wrap) begin
        tick_cnt <= '0;
      end else begin
        tick_cnt <= tick_cnt + TPM_W'(1);
      end
    end
  end

  // a zero rate would never wrap and stall the whole player
  a_tpm_nonzero : assert property (
    @(posedge clk) disable iff (rst) ticks_per_milli != '0
  );

endmodule

// File: source/music_pkg.sv
package music_pkg;

  // pitch in Hz, zero is a rest
  localparam int FREQ_W = 10;
  localparam int BEATS_W = 4;

  // millisecond counters hold up to 10 beats of BEAT_MS
  localparam int MS_W = 11;

  localparam int TPM_W = 16;  // clocks per millisecond input
  localparam int ACC_W = 32;  // phase accumulator and ticks per second

  localparam int BEAT_MS = 100;  // tempo, ms per beat
  localparam int MS_PER_S = 1000;

  // part numbering runs 1..NUM_PARTS
  // 1,2 intro and 3,4 chorus
  localparam int PART_W = 3;
  localparam int IDX_W = 6;
  localparam int NUM_PARTS = 4;

  localparam int INTRO_LAST = 12;  // last intro index
  localparam int CHORUS_LAST = 58;  // last chorus index

  // one score entry as read from the ROM
  typedef struct packed {
    logic [FREQ_W-1:0]  freq;
    logic [BEATS_W-1:0] beats;
  } note_t;

endpackage

// File: source/music_top.sv
module music_top import music_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic [TPM_W-1:0] ticks_per_milli,
  output logic [7:0]       led,
  output logic             sound
);

  logic              ms_strobe;
  logic [PART_W-1:0] part;
  logic [IDX_W-1:0]  note_idx;
  note_t             note;
  logic [FREQ_W-1:0] freq;
  logic              sounding;

  ms_tick u_ms_tick (
    .clk             (clk),
    .rst             (rst),
    .ticks_per_milli (ticks_per_milli),
    .ms_strobe       (ms_strobe)
  );

  score_rom u_score_rom (
    .part     (part),
    .note_idx (note_idx),
    .note     (note)
  );

  note_sequencer u_note_sequencer (
    .clk       (clk),
    .rst       (rst),
    .ms_strobe (ms_strobe),
    .note      (note),
    .part      (part),
    .note_idx  (note_idx),
    .freq      (freq),
    .sounding  (sounding)
  );

  tone_generator u_tone_generator (
    .clk             (clk),
    .rst             (rst),
    .ticks_per_milli (ticks_per_milli),
    .freq            (freq),
    .sound           (sound)
  );

  seg_display u_seg_display (
    .part     (part),
    .sounding (sounding),
    .led      (led)
  );

endmodule

// File: source/note_sequencer.sv
module note_sequencer import music_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              ms_strobe,
  input  note_t             note,
  output logic [PART_W-1:0] part,
  output logic [IDX_W-1:0]  note_idx,
  output logic [FREQ_W-1:0] freq,
  output logic              sounding
);

  typedef enum logic [1:0] {
    FETCH,
    PLAY,
    GAP
  } seq_state_t;

  seq_state_t       state;
  logic [MS_W-1:0]  len_ms;
  logic [MS_W-1:0]  ms_cnt;
  logic [MS_W-1:0]  gap_ms;
  logic [IDX_W-1:0] last_idx;

  assign gap_ms = len_ms / MS_W'(3);  // silent third after each note

  // parts 3 and 4 play the longer chorus table
  assign last_idx = (part > PART_W'(2)) ? IDX_W'(CHORUS_LAST) : IDX_W'(INTRO_LAST);

  assign sounding = (state == PLAY) && (freq != '0);

  always_ff @(posedge clk) begin
    if (state == FETCH) begin
      len_ms <= MS_W'(BEAT_MS * note.beats);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= FETCH;
      part     <= PART_W'(1);
      note_idx <= '0;
      freq     <= '0;
      ms_cnt   <= '0;
    end else begin
      case (state)
        FETCH: begin
          freq   <= note.freq;  // zero for a rest
          ms_cnt <= '0;
          state  <= PLAY;
        end

        PLAY: begin
          if (ms_cnt == len_ms) begin
            freq   <= '0;
            ms_cnt <= '0;
            state  <= GAP;
          end else if (ms_strobe) begin
            ms_cnt <= ms_cnt + MS_W'(1);
          end
        end

        GAP: begin
          if (ms_cnt == gap_ms) begin
            state <= FETCH;
            if (note_idx == last_idx) begin
              note_idx <= '0;
              // wrap back to the first intro
              if (part == PART_W'(NUM_PARTS)) begin
                part <= PART_W'(1);
              end else begin
                part <= part + PART_W'(1);
              end
            end else begin
              note_idx <= note_idx + IDX_W'(1);
            end
          end else if (ms_strobe) begin
            ms_cnt <= ms_cnt + MS_W'(1);
          end
        end

        default: state <= FETCH;
      endcase
    end
  end

  a_part_range : assert property (
    @(posedge clk) disable iff (rst)
      part >= PART_W'(1) && part <= PART_W'(NUM_PARTS)
  );

  // the tone generator must be quiet for the whole gap
  a_gap_silent : assert property (
    @(posedge clk) disable iff (rst) state == GAP |-> freq == '0
  );

endmodule

// File: source/score_rom.sv
module score_rom import music_pkg::*; (
  input  logic [PART_W-1:0] part,
  input  logic [IDX_W-1:0]  note_idx,
  output note_t             note
);

  localparam logic [FREQ_W-1:0] REST = 10'd0;
  localparam logic [FREQ_W-1:0] A4F = 10'd415;
  localparam logic [FREQ_W-1:0] B4F = 10'd466;
  localparam logic [FREQ_W-1:0] C5 = 10'd523;
  localparam logic [FREQ_W-1:0] C5S = 10'd554;
  localparam logic [FREQ_W-1:0] E5F = 10'd622;
  localparam logic [FREQ_W-1:0] F5 = 10'd698;
  localparam logic [FREQ_W-1:0] F5S = 10'd740;
  localparam logic [FREQ_W-1:0] A5F = 10'd831;

  logic intro_sel;

  assign intro_sel = (part == PART_W'(1)) || (part == PART_W'(2));

  always_comb begin
    note = '{REST, 4'd1};  // past the end of a table
    if (intro_sel) begin
      case (note_idx)
        6'd0:  note = '{C5S, 4'd6};
        6'd1:  note = '{E5F, 4'd10};
        6'd2:  note = '{E5F, 4'd6};
        6'd3:  note = '{F5, 4'd6};
        6'd4:  note = '{A5F, 4'd1};  // quick run down
        6'd5:  note = '{F5S, 4'd1};
        6'd6:  note = '{F5, 4'd1};
        6'd7:  note = '{E5F, 4'd1};
        6'd8:  note = '{C5S, 4'd6};
        6'd9:  note = '{E5F, 4'd10};
        6'd10: note = '{REST, 4'd4};
        6'd11: note = '{A4F, 4'd2};
        6'd12: note = '{A4F, 4'd10};
        default: ;
      endcase
    end else if (part == PART_W'(3) || part == PART_W'(4)) begin
      case (note_idx)
        6'd0:  note = '{B4F, 4'd1};
        6'd1:  note = '{B4F, 4'd1};
        6'd2:  note = '{A4F, 4'd1};
        6'd3:  note = '{A4F, 4'd1};
        6'd4:  note = '{F5, 4'd3};
        6'd5:  note = '{F5, 4'd3};
        6'd6:  note = '{E5F, 4'd6};
        6'd7:  note = '{B4F, 4'd1};
        6'd8:  note = '{B4F, 4'd1};
        6'd9:  note = '{A4F, 4'd1};
        6'd10: note = '{A4F, 4'd1};
        6'd11: note = '{E5F, 4'd3};
        6'd12: note = '{E5F, 4'd3};
        6'd13: note = '{C5S, 4'd3};
        6'd14: note = '{C5, 4'd1};
        6'd15: note = '{B4F, 4'd2};
        6'd16: note = '{C5S, 4'd1};
        6'd17: note = '{C5S, 4'd1};
        6'd18: note = '{C5S, 4'd1};
        6'd19: note = '{C5S, 4'd1};
        6'd20: note = '{C5S, 4'd3};
        6'd21: note = '{E5F, 4'd3};
        6'd22: note = '{C5, 4'd3};
        6'd23: note = '{B4F, 4'd1};
        6'd24: note = '{A4F, 4'd2};
        6'd25: note = '{A4F, 4'd2};
        6'd26: note = '{A4F, 4'd2};
        6'd27: note = '{E5F, 4'd4};
        6'd28: note = '{C5S, 4'd8};  // end of first phrase
        6'd29: note = '{B4F, 4'd1};
        6'd30: note = '{B4F, 4'd1};
        6'd31: note = '{A4F, 4'd1};
        6'd32: note = '{A4F, 4'd1};
        6'd33: note = '{F5, 4'd3};
        6'd34: note = '{F5, 4'd3};
        6'd35: note = '{E5F, 4'd6};
        6'd36: note = '{B4F, 4'd1};
        6'd37: note = '{B4F, 4'd1};
        6'd38: note = '{A4F, 4'd1};
        6'd39: note = '{A4F, 4'd1};
        6'd40: note = '{A5F, 4'd3};  // high note
        6'd41: note = '{C5, 4'd3};
        6'd42: note = '{C5S, 4'd3};
        6'd43: note = '{C5, 4'd1};
        6'd44: note = '{B4F, 4'd2};
        6'd45: note = '{C5S, 4'd1};
        6'd46: note = '{C5S, 4'd1};
        6'd47: note = '{C5S, 4'd1};
        6'd48: note = '{C5S, 4'd1};
        6'd49: note = '{C5S, 4'd3};
        6'd50: note = '{E5F, 4'd3};
        6'd51: note = '{C5, 4'd3};
        6'd52: note = '{B4F, 4'd1};
        6'd53: note = '{A4F, 4'd2};
        6'd54: note = '{REST, 4'd2};
        6'd55: note = '{A4F, 4'd2};
        6'd56: note = '{E5F, 4'd4};
        6'd57: note = '{C5S, 4'd8};
        6'd58: note = '{REST, 4'd4};  // breath before the repeat
        default: ;
      endcase
    end
  end

endmodule

// File: source/seg_display.sv
module seg_display import music_pkg::*; (
  input  logic [PART_W-1:0] part,
  input  logic              sounding,
  output logic [7:0]        led
);

  logic [3:0] digit;

  assign digit  = 4'(part);
  assign led[7] = sounding;  // note dot

  // segments are gfedcba, active high
  always_comb begin
    case (digit)
      4'd0:    led[6:0] = 7'b0111111;
      4'd1:    led[6:0] = 7'b0000110;
      4'd2:    led[6:0] = 7'b1011011;
      4'd3:    led[6:0] = 7'b1001111;
      4'd4:    led[6:0] = 7'b1100110;
      4'd5:    led[6:0] = 7'b1101101;
      4'd6:    led[6:0] = 7'b1111101;
      4'd7:    led[6:0] = 7'b0000111;
      4'd8:    led[6:0] = 7'b1111111;
      4'd9:    led[6:0] = 7'b1101111;
      default: led[6:0] = 7'b0000000;  // blank
    endcase
  end

endmodule

// File: source/tone_generator.sv
module tone_generator import music_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic [TPM_W-1:0]  ticks_per_milli,
  input  logic [FREQ_W-1:0] freq,
  output logic              sound
);

  logic [ACC_W-1:0] ticks_per_second;
  logic [ACC_W-1:0] half_period;
  logic [ACC_W-1:0] acc;
  logic [ACC_W-1:0] acc_next;

  assign ticks_per_second = ACC_W'(ticks_per_milli) * ACC_W'(MS_PER_S);
  assign half_period      = ticks_per_second >> 1;
  assign acc_next         = acc + ACC_W'(freq);

  // each half period of the output is ticks_per_second / (2 * freq) clocks
  always_ff @(posedge clk) begin
    if (rst) begin
      acc   <= '0;
      sound <= 1'b0;
    end else if (freq == '0) begin
      sound <= 1'b0;  // rest, phase kept
    end else if (acc_next >= half_period) begin
      acc   <= acc_next - half_period;
      sound <= ~sound;
    end else begin
      acc <= acc_next;
    end
  end

endmodule

// File: verification/music_tb.sv
module music_tb import music_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TPM = 4;  // clocks per ms in this run
  localparam int BEAT_LEN_MS = 100;
  localparam int RESET_CYCLES = 8;
  localparam int LEN_TOL = 8;  // clocks
  localparam int WINDOW = 1000;  // tone count window, clocks
  localparam int SETTLE = 100;  // skip the start of the note
  localparam int NOTE_LIMIT = 6000;  // longest note plus its gap
  localparam int SONG_LIMIT = 300_000;
  // the four parts run about 52,300 ms, some 210k clocks, plus the short tests
  localparam int TIMEOUT_CYCLES = 400_000;

  logic             clk = 1'b0;
  logic             rst;
  logic [TPM_W-1:0] ticks_per_milli;
  logic [7:0]       led;
  logic             sound;

  int   error_count = 0;
  int   silence_errors = 0;
  int   cycle_count = 0;
  logic prev_dot = 1'b0;

  // first three intro notes
  int intro_freq[3] = '{554, 622, 622};
  int intro_beats[3] = '{6, 10, 6};

  music_top DUT (
    .clk             (clk),
    .rst             (rst),
    .ticks_per_milli (ticks_per_milli),
    .led             (led),
    .sound           (sound)
  );

  always #2 clk = ~clk;  // 4 ns period

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("error count: %0d", error_count + silence_errors + 1);
      $display("Errors found");
      $finish;
    end
  end

  // sound must stay low once the dot has been off for a full cycle
  always @(negedge clk) begin
    if (!rst && !prev_dot && !led[7] && sound !== 1'b0) begin
      silence_errors++;
      $display("[FAIL] silence_in_gap: sound with the note dot off at cycle %0d expected 0, actual %b",
               cycle_count, sound);
    end
    prev_dot = led[7];
  end

  function automatic int shown_digit(input logic [6:0] seg);
    case (seg)
      7'b0111111: return 0;
      7'b0000110: return 1;
      7'b1011011: return 2;
      7'b1001111: return 3;
      7'b1100110: return 4;
      default:    return -1;  // blank or garbled
    endcase
  endfunction

  task automatic expect_equal(input string test, input string what,
                              input logic signed [31:0] expected,
                              input logic signed [31:0] actual);
    if (actual !== expected) begin
      error_count++;
      $display("[FAIL] %s: %s expected %0d, actual %0d", test, what, expected, actual);
    end
  endtask

  task automatic expect_near(input string test, input string what,
                             input int expected, input int actual, input int tol);
    if (actual < expected - tol || actual > expected + tol) begin
      error_count++;
      $display("[FAIL] %s: %s expected %0d +/- %0d, actual %0d",
               test, what, expected, tol, actual);
    end
  endtask

  task automatic report_missing(input string test, input string what);
    error_count++;
    $display("%s: %s did not happen in time", test, what);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
  endtask

  // cycles is -1 when the dot never reaches the level
  task automatic wait_for_dot(input logic level, input int limit, output int cycles);
    cycles = 0;
    while (led[7] !== level) begin
      if (cycles == limit) begin
        cycles = -1;
        return;
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic check_idle_outputs(input string when);
    expect_equal("reset_state", {when, " sound"}, 0, 32'(sound));
    expect_equal("reset_state", {when, " note dot"}, 0, 32'(led[7]));
    expect_equal("reset_state", {when, " part digit"}, 1, shown_digit(led[6:0]));
  endtask

  task automatic reset_state();
    @(posedge clk);
    #1;
    rst = 1'b1;
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check_idle_outputs("during reset");
      @(posedge clk);
    end
    #1;
    rst = 1'b0;
    @(negedge clk);
    check_idle_outputs("after reset");
  endtask

  task automatic note_duration();
    int cycles;
    int exp_high;
    int exp_gap;
    apply_reset();
    wait_for_dot(1'b1, NOTE_LIMIT, cycles);
    if (cycles < 0) begin
      report_missing("note_duration", "start of the first note");
      return;
    end
    for (int i = 0; i < 3; i++) begin
      exp_high = intro_beats[i] * BEAT_LEN_MS * TPM;
      exp_gap  = intro_beats[i] * BEAT_LEN_MS / 3 * TPM;  // a third of the note
      wait_for_dot(1'b0, NOTE_LIMIT, cycles);
      if (cycles < 0) begin
        report_missing("note_duration", $sformatf("end of note %0d", i));
        return;
      end
      expect_near("note_duration", $sformatf("note %0d sound clocks", i),
                  exp_high, cycles, LEN_TOL);
      wait_for_dot(1'b1, NOTE_LIMIT, cycles);
      if (cycles < 0) begin
        report_missing("note_duration", $sformatf("end of gap %0d", i));
        return;
      end
      expect_near("note_duration", $sformatf("gap %0d clocks", i), exp_gap, cycles, LEN_TOL);
    end
  endtask

  task automatic tone_rate();
    int   cycles;
    int   toggles;
    int   expected;
    logic last;
    // two toggles per period, TPM * 1000 clocks per second
    expected = WINDOW * 2 * intro_freq[0] / (TPM * 1000);
    apply_reset();
    wait_for_dot(1'b1, NOTE_LIMIT, cycles);
    if (cycles < 0) begin
      report_missing("tone_rate", "start of the first note");
      return;
    end
    repeat (SETTLE) @(negedge clk);
    last    = sound;
    toggles = 0;
    repeat (WINDOW) begin
      @(negedge clk);
      if (sound !== last) begin
        toggles++;
      end
      last = sound;
    end
    if (led[7] !== 1'b1) begin
      error_count++;
      $display("tone_rate: the first note ended inside the count window");
    end
    expect_near("tone_rate", "toggles in window", expected, toggles, 1);
  endtask

  task automatic part_sequence();
    int order[5] = '{1, 2, 3, 4, 1};
    int seen;
    int last;
    int cur;
    int cycles;
    apply_reset();
    @(negedge clk);
    last = shown_digit(led[6:0]);
    expect_equal("part_sequence", "part 0", order[0], last);
    seen   = 1;
    cycles = 0;
    while (seen < 5 && cycles < SONG_LIMIT) begin
      @(negedge clk);
      cycles++;
      cur = shown_digit(led[6:0]);
      if (cur != last) begin
        expect_equal("part_sequence", $sformatf("part %0d", seen), order[seen], cur);
        seen++;
        last = cur;
      end
    end
    if (seen < 5) begin
      error_count++;
      $display("part_sequence: the player did not come back to part 1 within %0d cycles",
               SONG_LIMIT);
    end
  endtask

  initial begin
    rst             = 1'b1;
    ticks_per_milli = TPM_W'(TPM);
    reset_state();
    note_duration();
    tone_rate();
    part_sequence();
    $display("error count: %0d", error_count + silence_errors);
    if (error_count + silence_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
